// File: filelist.f
+incdir+include
verilog/decode_pkg.sv
verilog/uop_if.sv
verilog/alu_decoder.sv
verilog/branch_decoder.sv
verilog/mem_decoder.sv
verilog/decode_select.sv
verilog/decode_stage.sv
verilog/decode_top.sv
verif/tb_decode.sv

// File: run.sh
#!/bin/sh
# Build and run the decode testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_decode -f filelist.f -o sim_decode &&
./obj_dir/sim_decode || exit 1

// File: include/decode_vectors.svh
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

typedef struct packed {
    logic [31:0] ir;
    logic [31:0] pc;
    logic [2:0]  cls;
    logic [3:0]  subtype;
    logic [3:0]  aluop;
    logic        src1_pc;
    logic [1:0]  src2;
    logic        regwrite;
    logic        memread;
    logic        memwrite;
    logic [4:0]  rj;
    logic [4:0]  rk;
    logic [4:0]  rd;
    logic [31:0] imm;
    logic [5:0]  ecode;
} vec_t;

// Columns: ir, pc, cls, subtype, aluop, src1_pc, src2, regwrite, memread, memwrite,
// rj, rk, rd, imm, ecode
function automatic vec_t vector_at(input int idx);
    vec_t v;
    v = '0;
    case (idx)
        0:  v = '{32'h00100823, 32'h1c000000, 0, 0, 4, 0, 0, 1, 0, 0, 1, 2, 3, 32'h0, 0}; // ADD.W
        1:  v = '{32'h001114c7, 32'h1c000000, 0, 0, 5, 0, 0, 1, 0, 0, 6, 5, 7, 32'h0, 0};
        2:  v = '{32'h00187c1f, 32'h1c000000, 0, 0, 8, 0, 0, 1, 0, 0, 0, 31, 31, 32'h0, 0};
        3:  v = '{32'h00140c85, 32'h1c000000, 0, 0, 2, 0, 0, 1, 0, 0, 4, 3, 5, 32'h0, 0};
        4:  v = '{32'h0048fc41, 32'h1c000000, 0, 0, 8, 0, 1, 1, 0, 0, 2, 0, 1, 32'h1f, 0}; // SRAI.W
        5:  v = '{32'h00409464, 32'h1c000000, 0, 0, 6, 0, 1, 1, 0, 0, 3, 0, 4, 32'h5, 0};
        6:  v = '{32'h02bffc22, 32'h1c000000, 0, 0, 4, 0, 1, 1, 0, 0, 1, 0, 2, 32'hffffffff, 0};
        7:  v = '{32'h022000a6, 32'h1c000000, 0, 0, 9, 0, 1, 1, 0, 0, 5, 0, 6, 32'hfffff800, 0};
        8:  v = '{32'h037ffce8, 32'h1c000000, 0, 0, 0, 0, 1, 1, 0, 0, 7, 0, 8, 32'h00000fff, 0};
        9:  v = '{32'h03a00001, 32'h1c000000, 0, 0, 1, 0, 1, 1, 0, 0, 0, 0, 1, 32'h00000800, 0};
        10: v = '{32'h03c48d2a, 32'h1c000000, 0, 0, 3, 0, 1, 1, 0, 0, 9, 0, 10, 32'h123, 0};
        11: v = '{32'h15579bc3, 32'h1c000000, 0, 0, 12, 0, 1, 1, 0, 0, 0, 0, 3, 32'habcde000, 0};
        12: v = '{32'h1c000025, 32'h1c000000, 0, 0, 4, 1, 1, 1, 0, 0, 0, 0, 5, 32'h00001000, 0};
        13: v = '{32'h4c001041, 32'h1c000000, 2, 0, 4, 1, 3, 1, 0, 0, 2, 0, 1, 32'h10, 0}; // JIRL
        14: v = '{32'h53fffbff, 32'h1c000000, 1, 0, 5, 0, 0, 0, 0, 0, 0, 0, 0, 32'hfffffff8, 0};
        15: v = '{32'h54000410, 32'h1c000000, 2, 1, 4, 1, 3, 1, 0, 0, 0, 0, 1, 32'h00400004, 0};
        16: v = '{32'h5bfffc64, 32'h1c000000, 1, 1, 5, 0, 2, 0, 0, 0, 3, 0, 4, 32'hfffffffc, 0};
        17: v = '{32'h5c002022, 32'h1c000000, 1, 2, 5, 0, 2, 0, 0, 0, 1, 0, 2, 32'h20, 0};
        18: v = '{32'h600004a6, 32'h1c000000, 1, 3, 9, 0, 2, 0, 0, 0, 5, 0, 6, 32'h4, 0};
        19: v = '{32'h66000000, 32'h1c000000, 1, 4, 9, 0, 2, 0, 0, 0, 0, 0, 0, 32'hfffe0000, 0};
        20: v = '{32'h680008e8, 32'h1c000000, 1, 5, 10, 0, 2, 0, 0, 0, 7, 0, 8, 32'h8, 0};
        21: v = '{32'h6c000c21, 32'h1c000000, 1, 6, 10, 0, 2, 0, 0, 0, 1, 0, 1, 32'hc, 0};
        22: v = '{32'h283ff064, 32'h1c000000, 3, 0, 4, 0, 1, 1, 1, 0, 3, 0, 4, 32'hfffffffc, 0};
        23: v = '{32'h28400822, 32'h1c000000, 3, 1, 4, 0, 1, 1, 1, 0, 1, 0, 2, 32'h2, 0};
        24: v = '{32'h289ffc43, 32'h1c000000, 3, 2, 4, 0, 1, 1, 1, 0, 2, 0, 3, 32'h7ff, 0};
        25: v = '{32'h29000085, 32'h1c000000, 3, 3, 4, 0, 1, 0, 0, 1, 4, 0, 5, 32'h0, 0};
        26: v = '{32'h29401021, 32'h1c000000, 3, 4, 4, 0, 1, 0, 0, 1, 1, 0, 1, 32'h4, 0};
        27: v = '{32'h29a00043, 32'h1c000000, 3, 5, 4, 0, 1, 0, 0, 1, 2, 0, 3, 32'hfffff800, 0};
        28: v = '{32'h2a000422, 32'h1c000000, 3, 6, 4, 0, 1, 1, 1, 0, 1, 0, 2, 32'h1, 0};
        29: v = '{32'h2a401863, 32'h1c000000, 3, 7, 4, 0, 1, 1, 1, 0, 3, 0, 3, 32'h6, 0};
        30: v = '{32'h00100823, 32'h1c000002, 4, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0, 8}; // ADEF
        31: v = '{32'h002a0000, 32'h1c000000, 4, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0, 12};
        32: v = '{32'h002b0005, 32'h1c000000, 4, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0, 11};
        33: v = '{32'h002a0000, 32'h1c000001, 4, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0, 8};
        34: v = '{32'h04000804, 32'h1c000000, 4, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0, 13}; // CSRRD
        35: v = '{32'h001c0c41, 32'h1c000000, 4, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0, 13}; // MUL.W
        36: v = '{32'h38720000, 32'h1c000000, 4, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0, 13}; // DBAR
        37: v = '{32'h00000000, 32'h1c000000, 4, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0, 13};
        38: v = '{32'h0012316a, 32'h1c000000, 0, 0, 9, 0, 0, 1, 0, 0, 11, 12, 10, 32'h0, 0}; // SLT
        39: v = '{32'h0012bdcd, 32'h1c000000, 0, 0, 10, 0, 0, 1, 0, 0, 14, 15, 13, 32'h0, 0};
        40: v = '{32'h0014ca30, 32'h1c000000, 0, 0, 0, 0, 0, 1, 0, 0, 17, 18, 16, 32'h0, 0};
        41: v = '{32'h00155693, 32'h1c000000, 0, 0, 1, 0, 0, 1, 0, 0, 20, 21, 19, 32'h0, 0};
        42: v = '{32'h0015e2f6, 32'h1c000000, 0, 0, 3, 0, 0, 1, 0, 0, 23, 24, 22, 32'h0, 0};
        43: v = '{32'h00176f59, 32'h1c000000, 0, 0, 6, 0, 0, 1, 0, 0, 26, 27, 25, 32'h0, 0};
        44: v = '{32'h0017fbbc, 32'h1c000000, 0, 0, 7, 0, 0, 1, 0, 0, 29, 30, 28, 32'h0, 0};
        45: v = '{32'h0044c462, 32'h1c000000, 0, 0, 7, 0, 1, 1, 0, 0, 3, 0, 2, 32'h11, 0};
        46: v = '{32'h026004a4, 32'h1c000000, 0, 0, 10, 0, 1, 1, 0, 0, 5, 0, 4, 32'hfffff801, 0};
        default: v = '0;
    endcase
    return v;
endfunction

`endif

// File: verif/tb_decode.sv
`default_nettype none

module tb_decode;

    `include "decode_vectors.svh"

    localparam int N_VEC       = 47;
    localparam int SEED        = 23;
    localparam int CYCLE_LIMIT = 30 * N_VEC + 20;

    logic                   clk;
    logic                   arst_n;
    logic                   in_valid;
    logic                   in_ready;
    logic [31:0]            ir;
    logic [31:0]            pc;
    logic                   out_valid;
    logic                   out_ready;
    decode_pkg::uop_class_e out_cls;
    logic [3:0]             out_subtype;
    decode_pkg::alu_op_e    out_aluop;
    logic                   out_src1_pc;
    decode_pkg::src2_e      out_src2;
    logic                   out_regwrite;
    logic                   out_memread;
    logic                   out_memwrite;
    logic [4:0]             out_rj;
    logic [4:0]             out_rk;
    logic [4:0]             out_rd;
    logic [31:0]            out_imm;
    logic [5:0]             out_ecode;
    int                     out_idx;
    int                     cycles;

    decode_top decode_top_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .ir           (ir),
        .pc           (pc),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_cls      (out_cls),
        .out_subtype  (out_subtype),
        .out_aluop    (out_aluop),
        .out_src1_pc  (out_src1_pc),
        .out_src2     (out_src2),
        .out_regwrite (out_regwrite),
        .out_memread  (out_memread),
        .out_memwrite (out_memwrite),
        .out_rj       (out_rj),
        .out_rk       (out_rk),
        .out_rd       (out_rd),
        .out_imm      (out_imm),
        .out_ecode    (out_ecode)
    );

    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want)
        begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, want);
            $display("Errors found");
            $fatal(1, "decoded output does not match the table");
        end
    endtask

    task automatic compare_row(input vec_t want);
        check_value("out_cls", 32'(out_cls), 32'(want.cls));
        check_value("out_subtype", 32'(out_subtype), 32'(want.subtype));
        check_value("out_aluop", 32'(out_aluop), 32'(want.aluop));
        check_value("out_src1_pc", 32'(out_src1_pc), 32'(want.src1_pc));
        check_value("out_src2", 32'(out_src2), 32'(want.src2));
        check_value("out_regwrite", 32'(out_regwrite), 32'(want.regwrite));
        check_value("out_memread", 32'(out_memread), 32'(want.memread));
        check_value("out_memwrite", 32'(out_memwrite), 32'(want.memwrite));
        check_value("out_rj", 32'(out_rj), 32'(want.rj));
        check_value("out_rk", 32'(out_rk), 32'(want.rk));
        check_value("out_rd", 32'(out_rd), 32'(want.rd));
        check_value("out_imm", out_imm, want.imm);
        check_value("out_ecode", 32'(out_ecode), 32'(want.ecode));
    endtask

    // Random back-pressure
    always @(posedge clk)
        out_ready <= 1'($urandom);

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("Errors found");
            $fatal(1, "timeout: not all decoded micro-ops arrived in time");
        end
        if (!arst_n)
            check_value("out_valid", 32'(out_valid), 32'd0);
        else if (out_valid && out_ready)
        begin
            if (out_idx >= N_VEC)
            begin
                $display("Errors found");
                $fatal(1, "more micro-ops came out than were sent in");
            end
            compare_row(vector_at(out_idx)); // Rows must leave in table order
            out_idx = out_idx + 1;
        end
    end

    initial
    begin
        vec_t row;
        void'($urandom(SEED));
        row       = vector_at(0);
        clk       = 1'b0;
        arst_n    = 1'b0;
        in_valid  = 1'b1; // Row 0 waits through reset
        ir        = row.ir;
        pc        = row.pc;
        out_ready = 1'b0;
        cycles    = 0;
        out_idx   = 0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        for (int i = 0; i < N_VEC; i++)
        begin
            row = vector_at(i);
            in_valid <= 1'b1;
            ir       <= row.ir;
            pc       <= row.pc;
            @(posedge clk);
            if (i == 0)
                check_value("out_valid", 32'(out_valid), 32'd0); // First edge after reset
            while (!in_ready)
                @(posedge clk);
        end
        in_valid <= 1'b0;
        wait (out_idx == N_VEC);
        repeat (4) @(posedge clk);
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/decode_top.sv
`default_nettype none

module decode_top (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           in_valid,
    output logic                           in_ready,
    input  logic [decode_pkg::XLEN-1:0]    ir,
    input  logic [decode_pkg::XLEN-1:0]    pc,
    output logic                           out_valid,
    input  logic                           out_ready,
    output decode_pkg::uop_class_e         out_cls,
    output logic [3:0]                     out_subtype,
    output decode_pkg::alu_op_e            out_aluop,
    output logic                           out_src1_pc,
    output decode_pkg::src2_e              out_src2,
    output logic                           out_regwrite,
    output logic                           out_memread,
    output logic                           out_memwrite,
    output logic [decode_pkg::REG_W-1:0]   out_rj,
    output logic [decode_pkg::REG_W-1:0]   out_rk,
    output logic [decode_pkg::REG_W-1:0]   out_rd,
    output logic [decode_pkg::XLEN-1:0]    out_imm,
    output logic [decode_pkg::ECODE_W-1:0] out_ecode
);

    uop_if alu_bus ();
    uop_if br_bus ();
    uop_if mem_bus ();

    decode_pkg::uop_t sel_uop;
    decode_pkg::uop_t reg_uop;

    alu_decoder alu_decoder_i (.ir(ir), .bus(alu_bus.group));
    branch_decoder branch_decoder_i (.ir(ir), .bus(br_bus.group));
    mem_decoder mem_decoder_i (.ir(ir), .bus(mem_bus.group));

    decode_select decode_select_i (
        .ir      (ir),
        .pc      (pc),
        .alu_bus (alu_bus.merge),
        .br_bus  (br_bus.merge),
        .mem_bus (mem_bus.merge),
        .uop     (sel_uop)
    );

    decode_stage decode_stage_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .uop_in    (sel_uop),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .uop_out   (reg_uop)
    );

    assign out_cls      = reg_uop.cls;
    assign out_subtype  = reg_uop.subtype;
    assign out_aluop    = reg_uop.aluop;
    assign out_src1_pc  = reg_uop.src1_pc;
    assign out_src2     = reg_uop.src2;
    assign out_regwrite = reg_uop.regwrite;
    assign out_memread  = reg_uop.memread;
    assign out_memwrite = reg_uop.memwrite;
    assign out_rj       = reg_uop.rj;
    assign out_rk       = reg_uop.rk;
    assign out_rd       = reg_uop.rd;
    assign out_imm      = reg_uop.imm;
    assign out_ecode    = reg_uop.ecode;

endmodule

`default_nettype wire

// File: verilog/decode_stage.sv
`default_nettype none

module decode_stage (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             in_valid,
    output logic             in_ready,
    input  decode_pkg::uop_t uop_in,
    output logic             out_valid,
    input  logic             out_ready,
    output decode_pkg::uop_t uop_out
);

    logic load;

    // Free slot, or the held entry leaves this cycle
    assign in_ready = !out_valid || out_ready;
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            out_valid <= 1'b0;
        else if (in_ready)
            out_valid <= in_valid;
    end

    always_ff @(posedge clk)
    begin
        if (load)
            uop_out <= uop_in;
    end

endmodule

`default_nettype wire

// File: verilog/decode_select.sv
`default_nettype none

module decode_select (
    input  logic [decode_pkg::XLEN-1:0] ir,
    input  logic [decode_pkg::XLEN-1:0] pc,
    uop_if.merge                        alu_bus,
    uop_if.merge                        br_bus,
    uop_if.merge                        mem_bus,
    output decode_pkg::uop_t            uop
);

    decode_pkg::uop_t              cand;
    logic                          rj_used;
    logic                          rk_used;
    logic                          any_hit;
    logic [decode_pkg::ECODE_W-1:0] ecode;

    assign any_hit = alu_bus.hit | br_bus.hit | mem_bus.hit;

    // Groups never overlap, so at most one hits
    always_comb
    begin
        cand    = alu_bus.uop;
        rj_used = alu_bus.rj_used;
        rk_used = alu_bus.rk_used;
        if (br_bus.hit)
        begin
            cand    = br_bus.uop;
            rj_used = br_bus.rj_used;
            rk_used = br_bus.rk_used;
        end
        else if (mem_bus.hit)
        begin
            cand    = mem_bus.uop;
            rj_used = mem_bus.rj_used;
            rk_used = mem_bus.rk_used;
        end
    end

    always_comb
    begin
        if (pc[1:0] != 2'b00)
            ecode = decode_pkg::ECODE_ADEF;
        else if (ir[31:15] == decode_pkg::IR_BREAK)
            ecode = decode_pkg::ECODE_BRK;
        else if (ir[31:15] == decode_pkg::IR_SYSCALL)
            ecode = decode_pkg::ECODE_SYS;
        else if (!any_hit)
            ecode = decode_pkg::ECODE_INE;
        else
            ecode = '0;
    end

    always_comb
    begin
        uop = cand;
        if (!rj_used)
            uop.rj = '0;
        if (!rk_used)
            uop.rk = '0;
        if (ecode != '0)
        begin
            uop       = '0; // Exception carries only its code
            uop.cls   = decode_pkg::CLS_EXCP;
            uop.ecode = ecode;
        end
    end

endmodule

`default_nettype wire

// File: verilog/mem_decoder.sv
`default_nettype none

module mem_decoder (
    input  logic [decode_pkg::XLEN-1:0] ir,
    uop_if.group                        bus
);

    logic kind_ok;
    logic store;

    always_comb
    begin
        kind_ok         = 1'b1;
        bus.uop         = '0;
        bus.uop.cls     = decode_pkg::CLS_MEM;
        bus.uop.aluop   = decode_pkg::ALU_ADD; // Address is rj plus offset
        bus.uop.src2    = decode_pkg::SRC2_IMM;
        bus.uop.rj      = ir[9:5];
        bus.uop.rd      = ir[4:0];
        bus.uop.imm     = {{20{ir[21]}}, ir[21:10]};
        case (ir[25:22])
            decode_pkg::MEM_LD_B:  bus.uop.subtype = 4'd0;
            decode_pkg::MEM_LD_H:  bus.uop.subtype = 4'd1;
            decode_pkg::MEM_LD_W:  bus.uop.subtype = 4'd2;
            decode_pkg::MEM_ST_B:  bus.uop.subtype = 4'd3;
            decode_pkg::MEM_ST_H:  bus.uop.subtype = 4'd4;
            decode_pkg::MEM_ST_W:  bus.uop.subtype = 4'd5;
            decode_pkg::MEM_LD_BU: bus.uop.subtype = 4'd6;
            decode_pkg::MEM_LD_HU: bus.uop.subtype = 4'd7;
            default:               kind_ok = 1'b0; // PRELD lands here too
        endcase
        store            = ir[24] && !ir[25];
        bus.hit          = kind_ok && (ir[31:26] == decode_pkg::OP_MEM);
        bus.uop.memwrite = store;
        bus.uop.memread  = !store;
        bus.uop.regwrite = !store;
        bus.rj_used      = 1'b1;
        bus.rk_used      = 1'b0;
    end

endmodule

`default_nettype wire

// File: verilog/branch_decoder.sv
`default_nettype none

module branch_decoder (
    input  logic [decode_pkg::XLEN-1:0] ir,
    uop_if.group                        bus
);

    logic [decode_pkg::XLEN-1:0] off16;
    logic [decode_pkg::XLEN-1:0] off26;

    assign off16 = {{14{ir[25]}}, ir[25:10], 2'b00};
    assign off26 = {{4{ir[9]}}, ir[9:0], ir[25:10], 2'b00}; // High part sits in ir[9:0]

    always_comb
    begin
        bus.hit         = 1'b1;
        bus.rj_used     = 1'b1;
        bus.rk_used     = 1'b0;
        bus.uop         = '0;
        bus.uop.cls     = decode_pkg::CLS_BRANCH;
        bus.uop.aluop   = decode_pkg::ALU_SUB;
        bus.uop.src2    = decode_pkg::SRC2_RD_REG;
        bus.uop.rj      = ir[9:5];
        bus.uop.rd      = ir[4:0];
        bus.uop.imm     = off16;
        bus.uop.subtype = 4'(ir[31:26] - decode_pkg::OP_BEQ + 6'd1); // BEQ 1 to BGEU 6
        case (ir[31:26])
            decode_pkg::OP_JIRL, decode_pkg::OP_BL:
            begin
                bus.uop.cls      = decode_pkg::CLS_LINK_BRANCH;
                bus.uop.aluop    = decode_pkg::ALU_ADD;
                bus.uop.src1_pc  = 1'b1;
                bus.uop.src2     = decode_pkg::SRC2_CONST4;
                bus.uop.regwrite = 1'b1;
                bus.uop.subtype  = {3'b0, ir[28]}; // JIRL 0, BL 1
                if (ir[28])
                begin
                    bus.rj_used = 1'b0;
                    bus.uop.rd  = 5'd1;
                    bus.uop.imm = off26;
                end
            end
            decode_pkg::OP_B:
            begin
                bus.rj_used     = 1'b0;
                bus.uop.subtype = 4'd0;
                bus.uop.src2    = decode_pkg::SRC2_REG;
                bus.uop.rd      = '0;
                bus.uop.imm     = off26;
            end
            decode_pkg::OP_BEQ, decode_pkg::OP_BNE: ;
            decode_pkg::OP_BLT, decode_pkg::OP_BGE:  bus.uop.aluop = decode_pkg::ALU_SLT;
            decode_pkg::OP_BLTU, decode_pkg::OP_BGEU: bus.uop.aluop = decode_pkg::ALU_SLTU;
            default: bus.hit = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/alu_decoder.sv
`default_nettype none

module alu_decoder (
    input  logic [decode_pkg::XLEN-1:0] ir,
    uop_if.group                        bus
);

    logic [decode_pkg::XLEN-1:0] imm_sx;
    logic [decode_pkg::XLEN-1:0] imm_zx;

    assign imm_sx = {{20{ir[21]}}, ir[21:10]};
    assign imm_zx = {20'b0, ir[21:10]};

    always_comb
    begin
        bus.hit          = 1'b1;
        bus.rj_used      = 1'b1;
        bus.rk_used      = 1'b0;
        bus.uop          = '0;
        bus.uop.cls      = decode_pkg::CLS_ALU;
        bus.uop.src2     = decode_pkg::SRC2_IMM;
        bus.uop.regwrite = 1'b1;
        bus.uop.rj       = ir[9:5];
        bus.uop.rk       = ir[14:10];
        bus.uop.rd       = ir[4:0];
        case (ir[31:26])
            decode_pkg::OP_GRP0:
                case (ir[25:22])
                    decode_pkg::SUB_3R:
                    begin
                        bus.rk_used  = 1'b1;
                        bus.uop.src2 = decode_pkg::SRC2_REG;
                        case (ir[21:15])
                            decode_pkg::FN3R_ADD:  bus.uop.aluop = decode_pkg::ALU_ADD;
                            decode_pkg::FN3R_SUB:  bus.uop.aluop = decode_pkg::ALU_SUB;
                            decode_pkg::FN3R_SLT:  bus.uop.aluop = decode_pkg::ALU_SLT;
                            decode_pkg::FN3R_SLTU: bus.uop.aluop = decode_pkg::ALU_SLTU;
                            decode_pkg::FN3R_NOR:  bus.uop.aluop = decode_pkg::ALU_NOR;
                            decode_pkg::FN3R_AND:  bus.uop.aluop = decode_pkg::ALU_AND;
                            decode_pkg::FN3R_OR:   bus.uop.aluop = decode_pkg::ALU_OR;
                            decode_pkg::FN3R_XOR:  bus.uop.aluop = decode_pkg::ALU_XOR;
                            decode_pkg::FN3R_SLL:  bus.uop.aluop = decode_pkg::ALU_SLL;
                            decode_pkg::FN3R_SRL:  bus.uop.aluop = decode_pkg::ALU_SRL;
                            decode_pkg::FN3R_SRA:  bus.uop.aluop = decode_pkg::ALU_SRA;
                            default:               bus.hit = 1'b0; // Also BREAK, SYSCALL
                        endcase
                    end
                    decode_pkg::SUB_SHIFT:
                    begin
                        bus.uop.imm = {27'b0, ir[14:10]};
                        bus.hit     = (ir[21:20] == 2'b00) && (ir[17:15] == 3'b001);
                        case (ir[19:18])
                            2'b00:   bus.uop.aluop = decode_pkg::ALU_SLL;
                            2'b01:   bus.uop.aluop = decode_pkg::ALU_SRL;
                            2'b10:   bus.uop.aluop = decode_pkg::ALU_SRA;
                            default: bus.hit = 1'b0;
                        endcase
                    end
                    decode_pkg::SUB_SLTI:
                    begin
                        bus.uop.aluop = decode_pkg::ALU_SLT;
                        bus.uop.imm   = imm_sx;
                    end
                    decode_pkg::SUB_SLTUI:
                    begin
                        bus.uop.aluop = decode_pkg::ALU_SLTU;
                        bus.uop.imm   = imm_sx;
                    end
                    decode_pkg::SUB_ADDI:
                    begin
                        bus.uop.aluop = decode_pkg::ALU_ADD;
                        bus.uop.imm   = imm_sx;
                    end
                    decode_pkg::SUB_ANDI:
                    begin
                        bus.uop.aluop = decode_pkg::ALU_AND;
                        bus.uop.imm   = imm_zx;
                    end
                    decode_pkg::SUB_ORI:
                    begin
                        bus.uop.aluop = decode_pkg::ALU_OR;
                        bus.uop.imm   = imm_zx;
                    end
                    decode_pkg::SUB_XORI:
                    begin
                        bus.uop.aluop = decode_pkg::ALU_XOR;
                        bus.uop.imm   = imm_zx;
                    end
                    default: bus.hit = 1'b0;
                endcase
            decode_pkg::OP_LU12I:
            begin
                bus.hit       = !ir[25];
                bus.rj_used   = 1'b0;
                bus.uop.aluop = decode_pkg::ALU_PASS_B;
                bus.uop.imm   = {ir[24:5], 12'b0};
            end
            decode_pkg::OP_PCADDU12I:
            begin
                bus.hit         = !ir[25];
                bus.rj_used     = 1'b0;
                bus.uop.aluop   = decode_pkg::ALU_ADD;
                bus.uop.src1_pc = 1'b1;
                bus.uop.imm     = {ir[24:5], 12'b0};
            end
            default: bus.hit = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/uop_if.sv
`default_nettype none

// Candidate micro-op from one opcode group
interface uop_if;

    logic             hit;
    decode_pkg::uop_t uop;
    logic             rj_used; // Slot holds a real register index
    logic             rk_used;

    modport group (
        output hit,
        output uop,
        output rj_used,
        output rk_used
    );

    modport merge (
        input hit,
        input uop,
        input rj_used,
        input rk_used
    );

endinterface

`default_nettype wire

// File: verilog/decode_pkg.sv
`default_nettype none

package decode_pkg;

    localparam int XLEN    = 32;
    localparam int REG_W   = 5;
    localparam int ECODE_W = 6;

    localparam logic [ECODE_W-1:0] ECODE_ADEF = 6'h08;
    localparam logic [ECODE_W-1:0] ECODE_SYS  = 6'h0B;
    localparam logic [ECODE_W-1:0] ECODE_BRK  = 6'h0C;
    localparam logic [ECODE_W-1:0] ECODE_INE  = 6'h0D;

    // Primary opcodes in ir[31:26]
    localparam logic [5:0] OP_GRP0      = 6'b000000;
    localparam logic [5:0] OP_LU12I     = 6'b000101;
    localparam logic [5:0] OP_PCADDU12I = 6'b000111;
    localparam logic [5:0] OP_MEM       = 6'b001010;
    localparam logic [5:0] OP_JIRL      = 6'b010011;
    localparam logic [5:0] OP_B         = 6'b010100;
    localparam logic [5:0] OP_BL        = 6'b010101;
    localparam logic [5:0] OP_BEQ       = 6'b010110;
    localparam logic [5:0] OP_BNE       = 6'b010111;
    localparam logic [5:0] OP_BLT       = 6'b011000;
    localparam logic [5:0] OP_BGE       = 6'b011001;
    localparam logic [5:0] OP_BLTU      = 6'b011010;
    localparam logic [5:0] OP_BGEU      = 6'b011011;

    // Group 0 minor opcodes in ir[25:22]
    localparam logic [3:0] SUB_3R    = 4'b0000;
    localparam logic [3:0] SUB_SHIFT = 4'b0001;
    localparam logic [3:0] SUB_SLTI  = 4'b1000;
    localparam logic [3:0] SUB_SLTUI = 4'b1001;
    localparam logic [3:0] SUB_ADDI  = 4'b1010;
    localparam logic [3:0] SUB_ANDI  = 4'b1101;
    localparam logic [3:0] SUB_ORI   = 4'b1110;
    localparam logic [3:0] SUB_XORI  = 4'b1111;

    // 3R function codes in ir[21:15]
    localparam logic [6:0] FN3R_ADD  = 7'b0100000;
    localparam logic [6:0] FN3R_SUB  = 7'b0100010;
    localparam logic [6:0] FN3R_SLT  = 7'b0100100;
    localparam logic [6:0] FN3R_SLTU = 7'b0100101;
    localparam logic [6:0] FN3R_NOR  = 7'b0101000;
    localparam logic [6:0] FN3R_AND  = 7'b0101001;
    localparam logic [6:0] FN3R_OR   = 7'b0101010;
    localparam logic [6:0] FN3R_XOR  = 7'b0101011;
    localparam logic [6:0] FN3R_SLL  = 7'b0101110;
    localparam logic [6:0] FN3R_SRL  = 7'b0101111;
    localparam logic [6:0] FN3R_SRA  = 7'b0110000;

    localparam logic [16:0] IR_BREAK   = 17'b000000_0000_1010100; // ir[31:15]
    localparam logic [16:0] IR_SYSCALL = 17'b000000_0000_1010110;

    // Memory size/kind in ir[25:22]
    localparam logic [3:0] MEM_LD_B  = 4'b0000;
    localparam logic [3:0] MEM_LD_H  = 4'b0001;
    localparam logic [3:0] MEM_LD_W  = 4'b0010;
    localparam logic [3:0] MEM_ST_B  = 4'b0100;
    localparam logic [3:0] MEM_ST_H  = 4'b0101;
    localparam logic [3:0] MEM_ST_W  = 4'b0110;
    localparam logic [3:0] MEM_LD_BU = 4'b1000;
    localparam logic [3:0] MEM_LD_HU = 4'b1001;

    typedef enum logic [2:0] {
        CLS_ALU         = 3'd0,
        CLS_BRANCH      = 3'd1,
        CLS_LINK_BRANCH = 3'd2,
        CLS_MEM         = 3'd3,
        CLS_EXCP        = 3'd4
    } uop_class_e;

    typedef enum logic [3:0] {
        ALU_AND = 4'd0, ALU_OR = 4'd1, ALU_NOR = 4'd2, ALU_XOR = 4'd3,
        ALU_ADD = 4'd4, ALU_SUB = 4'd5, ALU_SLL = 4'd6, ALU_SRL = 4'd7,
        ALU_SRA = 4'd8, ALU_SLT = 4'd9, ALU_SLTU = 4'd10, ALU_PASS_B = 4'd12
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC2_REG    = 2'd0,
        SRC2_IMM    = 2'd1,
        SRC2_RD_REG = 2'd2, // Compare against rd
        SRC2_CONST4 = 2'd3  // Link address pc+4
    } src2_e;

    typedef struct packed {
        uop_class_e         cls;
        logic [3:0]         subtype;
        alu_op_e            aluop;
        logic               src1_pc;
        src2_e              src2;
        logic               regwrite;
        logic               memread;
        logic               memwrite;
        logic [REG_W-1:0]   rj;
        logic [REG_W-1:0]   rk;
        logic [REG_W-1:0]   rd;
        logic [XLEN-1:0]    imm;
        logic [ECODE_W-1:0] ecode;
    } uop_t;

endpackage

`default_nettype wire
